//--- gpio_ctrl.sv
// always-on GPIO bank
// output and enable registers, synchronized inputs, rising-edge interrupts
`include "mcu_cfg.svh"

module gpio_ctrl (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  mcu_pkg::obi_req_t                   req_i,
  output mcu_pkg::obi_rsp_t                   rsp_o,
  input  logic [`MCU_GPIO_NUM-1:0]            gpio_i,
  output mcu_pkg::pad_t [`MCU_GPIO_NUM-1:0]   pad_o,
  output logic [`MCU_GPIO_NUM-1:0]            intr_o
);

  localparam int N = `MCU_GPIO_NUM;

  logic [N-1:0]           out_q;
  logic [N-1:0]           oe_q;
  logic [N-1:0]           ien_q;
  logic [N-1:0]           ist_q;
  logic [N-1:0]           sync_q;
  logic [N-1:0]           in_q;
  logic [N-1:0]           in_prev_q;
  logic [N-1:0]           rise;
  logic [N-1:0]           ist_clr;
  logic                   wr;
  logic [7:0]             ofs;
  logic [`MCU_DATA_W-1:0] rdata_d;
  logic [`MCU_DATA_W-1:0] rdata_q;
  logic                   rvalid_q;

  assign wr      = req_i.req & req_i.we;
  assign ofs     = req_i.addr[7:0];
  assign rise    = in_q & ~in_prev_q;
  assign ist_clr = (wr && ofs == `MCU_GPIO_IST_OFS) ? req_i.wdata[N-1:0] : '0;

  // two-flop synchronizer, then one more stage for edge detect
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sync_q    <= '0;
      in_q      <= '0;
      in_prev_q <= '0;
    end else begin
      sync_q    <= gpio_i;
      in_q      <= sync_q;
      in_prev_q <= in_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_q <= '0;
      oe_q  <= '0;
      ien_q <= '0;
      ist_q <= '0;
    end else begin
      if (wr) begin
        case (ofs)
          `MCU_GPIO_OUT_OFS: out_q <= req_i.wdata[N-1:0];
          `MCU_GPIO_OE_OFS:  oe_q <= req_i.wdata[N-1:0];
          `MCU_GPIO_IEN_OFS: ien_q <= req_i.wdata[N-1:0];
          default: ;
        endcase
      end
      // a new edge wins over write-one-to-clear
      ist_q <= (ist_q & ~ist_clr) | (rise & ien_q);
    end
  end

  always_comb begin
    rdata_d = '0;
    case (ofs)
      `MCU_GPIO_OUT_OFS: rdata_d[N-1:0] = out_q;
      `MCU_GPIO_OE_OFS:  rdata_d[N-1:0] = oe_q;
      `MCU_GPIO_IN_OFS:  rdata_d[N-1:0] = in_q;
      `MCU_GPIO_IEN_OFS: rdata_d[N-1:0] = ien_q;
      `MCU_GPIO_IST_OFS: rdata_d[N-1:0] = ist_q;
      default: ;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_q <= rdata_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
    end
  end

  // always ready, so grant follows request
  assign rsp_o.gnt    = req_i.req;
  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.err    = 1'b0;
  assign rsp_o.rdata  = rdata_q;

  always_comb begin
    for (int i = 0; i < N; i++) begin
      pad_o[i].o  = out_q[i];
      pad_o[i].oe = oe_q[i];
    end
  end

  assign intr_o = ist_q & ien_q;

endmodule

//--- mcu_cfg.svh
// always-on slice configuration
// address map, register offsets, pin count and interrupt positions
`ifndef MCU_CFG_SVH
`define MCU_CFG_SVH

`define MCU_GPIO_NUM 8
`define MCU_ADDR_W 32
`define MCU_DATA_W 32

// 64 KiB regions, selected by addr[31:16]
`define MCU_GPIO_BASE 32'h2000_0000
`define MCU_PWR_BASE 32'h2001_0000

// gpio register offsets
`define MCU_GPIO_OUT_OFS 8'h00
`define MCU_GPIO_OE_OFS 8'h04
`define MCU_GPIO_IN_OFS 8'h08
`define MCU_GPIO_IEN_OFS 8'h0C
`define MCU_GPIO_IST_OFS 8'h10

// power register offsets
`define MCU_PWR_CTRL_OFS 8'h00
`define MCU_PWR_STAT_OFS 8'h04

// status codes, anything else is a sequence in progress
`define MCU_PWR_ST_ON 0
`define MCU_PWR_ST_OFF 1

// gpio interrupt 0 lands on fast interrupt position 22
`define MCU_IRQ_GPIO_LSB 22

`endif

//--- mcu_pkg.sv
// shared types for the always-on slice
// OBI request/response, pad controls and power-domain controls
`include "mcu_cfg.svh"

package mcu_pkg;

  // master to slave
  typedef struct packed {
    logic                   req;
    logic                   we;
    logic [`MCU_ADDR_W-1:0] addr;
    logic [`MCU_DATA_W-1:0] wdata;
  } obi_req_t;

  // slave to master, rvalid one cycle after the grant
  typedef struct packed {
    logic                   gnt;
    logic                   rvalid;
    logic                   err;
    logic [`MCU_DATA_W-1:0] rdata;
  } obi_rsp_t;

  typedef struct packed {
    logic o;
    logic oe;
  } pad_t;

  // all active low
  typedef struct packed {
    logic pwrgate_en_n;
    logic isogate_en_n;
    logic rst_n;
    logic clkgate_en_n;
  } pwr_ctrl_t;

endpackage

//--- mcu_top.sv
// always-on bus slave slice of the MCU
// bus demux, GPIO bank, power controller and core interrupt vector
`include "mcu_cfg.svh"

module mcu_top (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  mcu_pkg::obi_req_t                 obi_req_i,
  output mcu_pkg::obi_rsp_t                 obi_rsp_o,
  input  logic [`MCU_GPIO_NUM-1:0]          gpio_i,
  output mcu_pkg::pad_t [`MCU_GPIO_NUM-1:0] gpio_pad_o,
  input  logic                              pwrgate_ack_n_i,
  output mcu_pkg::pwr_ctrl_t                pwr_o,
  output logic [31:0]                       irq_o
);

  mcu_pkg::obi_req_t          gpio_req;
  mcu_pkg::obi_rsp_t          gpio_rsp;
  mcu_pkg::obi_req_t          pwr_req;
  mcu_pkg::obi_rsp_t          pwr_rsp;
  logic [`MCU_GPIO_NUM-1:0]   gpio_intr;

  obi_demux obi_demux_i (
    .clk_i,
    .rst_i,
    .req_i     (obi_req_i),
    .rsp_o     (obi_rsp_o),
    .gpio_req_o(gpio_req),
    .gpio_rsp_i(gpio_rsp),
    .pwr_req_o (pwr_req),
    .pwr_rsp_i (pwr_rsp)
  );

  gpio_ctrl gpio_ctrl_i (
    .clk_i,
    .rst_i,
    .req_i (gpio_req),
    .rsp_o (gpio_rsp),
    .gpio_i(gpio_i),
    .pad_o (gpio_pad_o),
    .intr_o(gpio_intr)
  );

  power_ctrl power_ctrl_i (
    .clk_i,
    .rst_i,
    .req_i          (pwr_req),
    .rsp_o          (pwr_rsp),
    .pwrgate_ack_n_i(pwrgate_ack_n_i),
    .pwr_o          (pwr_o)
  );

  // gpio sits in the fast interrupt field, everything else unused here
  always_comb begin
    irq_o = '0;
    irq_o[`MCU_IRQ_GPIO_LSB+:`MCU_GPIO_NUM] = gpio_intr;
  end

endmodule

//--- obi_demux.sv
// OBI address demultiplexer for the always-on targets
// routes each request to GPIO or power, answers unmapped addresses with an error
`include "mcu_cfg.svh"

module obi_demux (
  input  logic              clk_i,
  input  logic              rst_i,
  input  mcu_pkg::obi_req_t req_i,
  output mcu_pkg::obi_rsp_t rsp_o,
  output mcu_pkg::obi_req_t gpio_req_o,
  input  mcu_pkg::obi_rsp_t gpio_rsp_i,
  output mcu_pkg::obi_req_t pwr_req_o,
  input  mcu_pkg::obi_rsp_t pwr_rsp_i
);

  localparam logic [`MCU_ADDR_W-1:0] GPIO_BASE = `MCU_GPIO_BASE;
  localparam logic [`MCU_ADDR_W-1:0] PWR_BASE = `MCU_PWR_BASE;

  typedef enum logic [1:0] {
    SEL_NONE,
    SEL_GPIO,
    SEL_PWR,
    SEL_ERR
  } sel_e;

  logic gpio_hit;
  logic pwr_hit;
  logic gnt;
  sel_e sel_d;
  sel_e sel_q;

  assign gpio_hit = req_i.addr[`MCU_ADDR_W-1:16] == GPIO_BASE[`MCU_ADDR_W-1:16];
  assign pwr_hit  = req_i.addr[`MCU_ADDR_W-1:16] == PWR_BASE[`MCU_ADDR_W-1:16];

  always_comb begin
    gpio_req_o     = req_i;
    gpio_req_o.req = req_i.req & gpio_hit;
    pwr_req_o      = req_i;
    pwr_req_o.req  = req_i.req & pwr_hit;
  end

  // unmapped requests are granted here
  always_comb begin
    if (gpio_hit) begin
      gnt = gpio_rsp_i.gnt;
    end else if (pwr_hit) begin
      gnt = pwr_rsp_i.gnt;
    end else begin
      gnt = req_i.req;
    end
  end

  always_comb begin
    sel_d = SEL_NONE;
    if (req_i.req && gnt) begin
      if (gpio_hit) begin
        sel_d = SEL_GPIO;
      end else if (pwr_hit) begin
        sel_d = SEL_PWR;
      end else begin
        sel_d = SEL_ERR;
      end
    end
  end

  // remembers who answers in the next cycle
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sel_q <= SEL_NONE;
    end else begin
      sel_q <= sel_d;
    end
  end

  always_comb begin
    rsp_o     = '0;
    rsp_o.gnt = gnt;
    case (sel_q)
      SEL_GPIO: begin
        rsp_o.rvalid = gpio_rsp_i.rvalid;
        rsp_o.err    = gpio_rsp_i.err;
        rsp_o.rdata  = gpio_rsp_i.rdata;
      end
      SEL_PWR: begin
        rsp_o.rvalid = pwr_rsp_i.rvalid;
        rsp_o.err    = pwr_rsp_i.err;
        rsp_o.rdata  = pwr_rsp_i.rdata;
      end
      SEL_ERR: begin
        rsp_o.rvalid = 1'b1;
        rsp_o.err    = 1'b1;
      end
      default: begin
        rsp_o.rvalid = 1'b0;
      end
    endcase
  end

endmodule

//--- power_ctrl.sv
// power controller for one switchable domain
// sequences clock gate, isolation, reset and power switch against the switch ack
`include "mcu_cfg.svh"

module power_ctrl (
  input  logic               clk_i,
  input  logic               rst_i,
  input  mcu_pkg::obi_req_t  req_i,
  output mcu_pkg::obi_rsp_t  rsp_o,
  input  logic               pwrgate_ack_n_i,
  output mcu_pkg::pwr_ctrl_t pwr_o
);

  typedef enum logic [3:0] {
    ST_ON       = 4'(`MCU_PWR_ST_ON),
    ST_OFF      = 4'(`MCU_PWR_ST_OFF),
    ST_CLK_GATE = 4'd2,
    ST_ISO      = 4'd3,
    ST_RST      = 4'd4,
    ST_SW_OFF   = 4'd5,
    ST_SW_ON    = 4'd6,
    ST_RST_REL  = 4'd7,
    ST_ISO_REL  = 4'd8
  } state_e;

  state_e                 state_d;
  state_e                 state_q;
  mcu_pkg::pwr_ctrl_t     pwr_d;
  mcu_pkg::pwr_ctrl_t     pwr_q;
  logic                   ctrl_q;
  logic                   wr;
  logic [7:0]             ofs;
  logic [`MCU_DATA_W-1:0] rdata_d;
  logic [`MCU_DATA_W-1:0] rdata_q;
  logic                   rvalid_q;

  assign wr  = req_i.req & req_i.we;
  assign ofs = req_i.addr[7:0];

  // requested state, 1 means off
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ctrl_q <= 1'b0;
    end else if (wr && ofs == `MCU_PWR_CTRL_OFS) begin
      ctrl_q <= req_i.wdata[0];
    end
  end

  // each state entry changes one control field
  always_comb begin
    state_d = state_q;
    pwr_d   = pwr_q;
    case (state_q)
      ST_ON: begin
        if (ctrl_q) begin
          state_d            = ST_CLK_GATE;
          pwr_d.clkgate_en_n = 1'b0;
        end
      end
      ST_CLK_GATE: begin
        state_d            = ST_ISO;
        pwr_d.isogate_en_n = 1'b0;
      end
      ST_ISO: begin
        state_d     = ST_RST;
        pwr_d.rst_n = 1'b0;
      end
      ST_RST: begin
        state_d            = ST_SW_OFF;
        pwr_d.pwrgate_en_n = 1'b0;
      end
      ST_SW_OFF: begin
        if (!pwrgate_ack_n_i) begin
          state_d = ST_OFF;
        end
      end
      ST_OFF: begin
        if (!ctrl_q) begin
          state_d            = ST_SW_ON;
          pwr_d.pwrgate_en_n = 1'b1;
        end
      end
      // switch must report the domain powered before anything else
      ST_SW_ON: begin
        if (pwrgate_ack_n_i) begin
          state_d     = ST_RST_REL;
          pwr_d.rst_n = 1'b1;
        end
      end
      ST_RST_REL: begin
        state_d            = ST_ISO_REL;
        pwr_d.isogate_en_n = 1'b1;
      end
      ST_ISO_REL: begin
        state_d            = ST_ON;
        pwr_d.clkgate_en_n = 1'b1;
      end
      default: state_d = ST_ON;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= ST_ON;
      pwr_q   <= '1;
    end else begin
      state_q <= state_d;
      pwr_q   <= pwr_d;
    end
  end

  always_comb begin
    rdata_d = '0;
    case (ofs)
      `MCU_PWR_CTRL_OFS: rdata_d[0] = ctrl_q;
      `MCU_PWR_STAT_OFS: rdata_d[3:0] = state_q;
      default: ;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_q <= rdata_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
    end
  end

  assign rsp_o.gnt    = req_i.req;
  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.err    = 1'b0;
  assign rsp_o.rdata  = rdata_q;
  assign pwr_o        = pwr_q;

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f verilog.f --top-module tb_mcu -Mdir obj_dir
./obj_dir/Vtb_mcu | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
  exit 0
else
  exit 1
fi

//--- tb_mcu.sv
// testbench for the always-on MCU slice
// drives the OBI port, GPIO pins and switch acknowledge
// assertions compare the responses
`include "mcu_cfg.svh"

module tb_mcu;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N = `MCU_GPIO_NUM;
  // about four times the length of all tests together
  localparam int MAX_CYCLES = 500;
  localparam logic [31:0] GPIO_OUT = `MCU_GPIO_BASE + `MCU_GPIO_OUT_OFS;
  localparam logic [31:0] GPIO_OE = `MCU_GPIO_BASE + `MCU_GPIO_OE_OFS;
  localparam logic [31:0] GPIO_IN = `MCU_GPIO_BASE + `MCU_GPIO_IN_OFS;
  localparam logic [31:0] GPIO_IEN = `MCU_GPIO_BASE + `MCU_GPIO_IEN_OFS;
  localparam logic [31:0] GPIO_IST = `MCU_GPIO_BASE + `MCU_GPIO_IST_OFS;
  localparam logic [31:0] PWR_CTRL = `MCU_PWR_BASE + `MCU_PWR_CTRL_OFS;
  localparam logic [31:0] PWR_STAT = `MCU_PWR_BASE + `MCU_PWR_STAT_OFS;
  localparam logic [31:0] UNMAPPED = 32'h3000_0000;
  localparam logic [31:0] ST_ON = `MCU_PWR_ST_ON;
  localparam logic [31:0] ST_OFF = `MCU_PWR_ST_OFF;

  logic                  clk;
  logic                  rst;
  mcu_pkg::obi_req_t     obi_req;
  mcu_pkg::obi_rsp_t     obi_rsp;
  logic [N-1:0]          gpio_in;
  mcu_pkg::pad_t [N-1:0] pads;
  logic                  pwrgate_ack_n;
  mcu_pkg::pwr_ctrl_t    pwr;
  logic [31:0]           irq;
  logic [31:0]           ien_shadow;
  logic [31:0]           irq_allowed;
  logic [31:0]           out_shadow;
  logic [31:0]           lfsr_q;
  int                    errors;
  int                    tests_run;
  int                    tests_failed;
  int                    cycles;

  mcu_top uut (
    .clk_i          (clk),
    .rst_i          (rst),
    .obi_req_i      (obi_req),
    .obi_rsp_o      (obi_rsp),
    .gpio_i         (gpio_in),
    .gpio_pad_o     (pads),
    .pwrgate_ack_n_i(pwrgate_ack_n),
    .pwr_o          (pwr),
    .irq_o          (irq)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run stopped after %0d cycles", cycles);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // irq bits allowed by the enabled gpio pins
  assign irq_allowed = ien_shadow << `MCU_IRQ_GPIO_LSB;

  a_rvalid_after_gnt: assert property (@(posedge clk) disable iff (rst)
    (obi_req.req && obi_rsp.gnt) |=> obi_rsp.rvalid)
    else begin
      $display("ERR rvalid=%h expected 1 one cycle after grant", obi_rsp.rvalid);
      errors++;
    end
  a_no_rvalid: assert property (@(posedge clk) disable iff (rst)
    !(obi_req.req && obi_rsp.gnt) |=> !obi_rsp.rvalid)
    else begin
      $display("ERR rvalid=%h expected 0 without grant", obi_rsp.rvalid);
      errors++;
    end
  a_irq_masked: assert property (@(posedge clk) disable iff (rst)
    (irq & ~irq_allowed) == '0)
    else begin
      $display("ERR irq_o=%h allowed %h", irq, irq_allowed);
      errors++;
    end
  a_iso_after_clk: assert property (@(posedge clk) disable iff (rst)
    $fell(pwr.clkgate_en_n) |=> $fell(pwr.isogate_en_n))
    else begin
      $display("ERR isogate_en_n=%h expected fall after clkgate_en_n", pwr.isogate_en_n);
      errors++;
    end
  a_rst_after_iso: assert property (@(posedge clk) disable iff (rst)
    $fell(pwr.isogate_en_n) |=> $fell(pwr.rst_n))
    else begin
      $display("ERR rst_n=%h expected fall after isogate_en_n", pwr.rst_n);
      errors++;
    end
  a_sw_after_rst: assert property (@(posedge clk) disable iff (rst)
    $fell(pwr.rst_n) |=> $fell(pwr.pwrgate_en_n))
    else begin
      $display("ERR pwrgate_en_n=%h expected fall after rst_n", pwr.pwrgate_en_n);
      errors++;
    end
  a_rst_rel_on_ack: assert property (@(posedge clk) disable iff (rst)
    $rose(pwr.rst_n) |-> (pwr.pwrgate_en_n && $past(pwrgate_ack_n)))
    else begin
      $display("ERR pwrgate_ack_n_i=%h expected 1 when rst_n rises", $past(pwrgate_ack_n));
      errors++;
    end
  a_iso_rel_after_rst: assert property (@(posedge clk) disable iff (rst)
    $rose(pwr.rst_n) |=> $rose(pwr.isogate_en_n))
    else begin
      $display("ERR isogate_en_n=%h expected rise after rst_n", pwr.isogate_en_n);
      errors++;
    end
  a_clk_rel_after_iso: assert property (@(posedge clk) disable iff (rst)
    $rose(pwr.isogate_en_n) |=> $rose(pwr.clkgate_en_n))
    else begin
      $display("ERR clkgate_en_n=%h expected rise after isogate_en_n", pwr.clkgate_en_n);
      errors++;
    end

  // taps of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic [31:0] pad_field(input logic want_oe);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < N; i++) begin
      v[i] = want_oe ? pads[i].oe : pads[i].o;
    end
    return v;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #10;
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
    else begin
      $display("ERR %s=%h expected %h", what, got, exp);
      errors++;
    end
  endtask

  task automatic note_failure(input string msg);
    $display("%s", msg);
    errors++;
  endtask

  // returns in the response cycle with the request dropped
  task automatic transfer(input logic we, input logic [31:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output logic err);
    logic granted;
    int   waited;
    obi_req.req   = 1'b1;
    obi_req.we    = we;
    obi_req.addr  = addr;
    obi_req.wdata = wdata;
    granted       = 1'b0;
    waited        = 0;
    while (!granted && waited < 8) begin
      @(posedge clk);
      granted = obi_rsp.gnt;
      #10;
      waited++;
    end
    obi_req = '0;
    if (!granted) begin
      note_failure($sformatf("request to %h was never granted", addr));
    end
    waited = 0;
    while (!obi_rsp.rvalid && waited < 8) begin
      next_cycle();
      waited++;
    end
    if (!obi_rsp.rvalid) begin
      note_failure($sformatf("no response from %h", addr));
    end
    rdata = obi_rsp.rdata;
    err   = obi_rsp.err;
  endtask

  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] rdata;
    logic        err;
    transfer(1'b1, addr, data, rdata, err);
    assert (!err)
    else begin
      $display("ERR err=%h expected 0 on write to %h", err, addr);
      errors++;
    end
  endtask

  task automatic read_check(input logic [31:0] addr, input logic [31:0] exp,
                            input string what);
    logic [31:0] rdata;
    logic        err;
    transfer(1'b0, addr, '0, rdata, err);
    check_value({what, " err"}, {31'h0, err}, 32'h0);
    check_value(what, rdata, exp);
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - errs_before);
    end
  endtask

  task automatic reset_state();
    check_value("rvalid", {31'h0, obi_rsp.rvalid}, 32'h0);
    check_value("pad o", pad_field(1'b0), 32'h0);
    check_value("pad oe", pad_field(1'b1), 32'h0);
    check_value("irq_o", irq, 32'h0);
    check_value("pwr_o", {28'h0, pwr}, 32'hf);
  endtask

  task automatic gpio_output();
    logic [31:0] oe_v;
    for (int r = 0; r < 3; r++) begin
      out_shadow = rand_bits(N);
      oe_v       = rand_bits(N);
      write_reg(GPIO_OUT, out_shadow);
      check_value("pad o", pad_field(1'b0), out_shadow);
      write_reg(GPIO_OE, oe_v);
      check_value("pad oe", pad_field(1'b1), oe_v);
      read_check(GPIO_OUT, out_shadow, "gpio out");
      read_check(GPIO_OE, oe_v, "gpio oe");
    end
  endtask

  task automatic gpio_interrupts();
    logic [31:0] pins;
    logic [31:0] ien_v;
    int          waited;
    pins    = rand_bits(N);
    gpio_in = pins[N-1:0];
    repeat (3) next_cycle();
    read_check(GPIO_IN, pins, "gpio in");
    gpio_in = '0;
    repeat (3) next_cycle();
    // pin 0 always enabled and the top pin never
    ien_v = (rand_bits(N) | 32'h1) & 32'h7f;
    write_reg(GPIO_IEN, ien_v);
    ien_shadow = ien_v;
    write_reg(GPIO_IST, 32'hff);
    for (int n = 0; n < N; n++) begin
      gpio_in[n] = 1'b1;
      waited = 0;
      while (!irq[`MCU_IRQ_GPIO_LSB + n] && waited < 3) begin
        next_cycle();
        waited++;
      end
      if (ien_v[n]) begin
        if (!irq[`MCU_IRQ_GPIO_LSB + n]) begin
          note_failure($sformatf("interrupt of pin %0d did not rise in 3 cycles", n));
        end
        write_reg(GPIO_IST, 32'h1 << n);
      end
      check_value("irq_o", irq, 32'h0);
      gpio_in[n] = 1'b0;
    end
    write_reg(GPIO_IEN, 32'h0);
    ien_shadow = '0;
  endtask

  task automatic power_sequence();
    logic [31:0] stat;
    logic        err;
    int          delay;
    int          waited;
    write_reg(PWR_CTRL, 32'h1);
    read_check(PWR_CTRL, 32'h1, "pwr ctrl");
    // long enough to read STAT after the switch was told to open
    delay = 5 + int'(rand_bits(3));
    for (int i = 0; i < delay; i++) begin
      transfer(1'b0, PWR_STAT, '0, stat, err);
      assert (stat != ST_OFF)
      else begin
        $display("ERR stat=%h reached OFF before the switch acknowledge", stat);
        errors++;
      end
    end
    pwrgate_ack_n = 1'b0;
    stat   = '1;
    waited = 0;
    while (stat != ST_OFF && waited < 8) begin
      transfer(1'b0, PWR_STAT, '0, stat, err);
      waited++;
    end
    check_value("stat", stat, ST_OFF);
    check_value("pwr_o", {28'h0, pwr}, 32'h0);
    // nothing may move before the acknowledge rises
    write_reg(PWR_CTRL, 32'h0);
    delay = 2 + int'(rand_bits(3));
    for (int i = 0; i < delay; i++) begin
      transfer(1'b0, PWR_STAT, '0, stat, err);
      check_value("rst_n", {31'h0, pwr.rst_n}, 32'h0);
      assert (stat != ST_ON)
      else begin
        $display("ERR stat=%h reached ON before the switch acknowledge", stat);
        errors++;
      end
    end
    pwrgate_ack_n = 1'b1;
    waited = 0;
    while (stat != ST_ON && waited < 8) begin
      transfer(1'b0, PWR_STAT, '0, stat, err);
      waited++;
    end
    check_value("stat", stat, ST_ON);
    check_value("pwr_o", {28'h0, pwr}, 32'hf);
  endtask

  task automatic unmapped_access();
    logic [31:0] rdata;
    logic [31:0] pins;
    logic        err;
    transfer(1'b0, UNMAPPED, '0, rdata, err);
    check_value("err", {31'h0, err}, 32'h1);
    check_value("rdata", rdata, 32'h0);
    transfer(1'b1, `MCU_GPIO_BASE + 32'h0002_0000, 32'hffff_ffff, rdata, err);
    check_value("err", {31'h0, err}, 32'h1);
    read_check(GPIO_OUT, out_shadow, "gpio out");
    read_check(PWR_CTRL, 32'h0, "pwr ctrl");
    pins    = rand_bits(N);
    gpio_in = pins[N-1:0];
    repeat (3) next_cycle();
    write_reg(GPIO_IN, ~pins);
    read_check(GPIO_IN, pins, "gpio in");
    read_check(GPIO_OUT, out_shadow, "gpio out");
  endtask

  task automatic back_to_back();
    logic [31:0] exp_q[$];
    logic [31:0] exp;
    logic        granted;
    out_shadow = rand_bits(N - 1) | 32'h80;
    write_reg(GPIO_OUT, out_shadow);
    for (int i = 0; i <= 8; i++) begin
      if (i > 0) begin
        exp = exp_q.pop_front();
        if (!obi_rsp.rvalid) begin
          note_failure($sformatf("back-to-back response %0d missing", i - 1));
        end
        check_value("rdata", obi_rsp.rdata, exp);
      end
      if (i < 8) begin
        obi_req.req   = 1'b1;
        obi_req.we    = 1'b0;
        obi_req.wdata = '0;
        obi_req.addr  = (i % 2 == 1) ? PWR_STAT : GPIO_OUT;
        exp_q.push_back((i % 2 == 1) ? ST_ON : out_shadow);
      end else begin
        obi_req = '0;
      end
      @(posedge clk);
      granted = obi_rsp.gnt;
      #10;
      if (i < 8 && !granted) begin
        note_failure($sformatf("back-to-back request %0d not granted", i));
      end
    end
  endtask

  initial begin
    int errs_before;
    rst           = 1'b1;
    obi_req       = '0;
    gpio_in       = '0;
    pwrgate_ack_n = 1'b1;
    ien_shadow    = '0;
    out_shadow    = '0;
    lfsr_q        = 32'ha0d5;
    errors        = 0;
    tests_run     = 0;
    tests_failed  = 0;
    cycles        = 0;
    repeat (10) @(posedge clk);
    #10;
    rst = 1'b0;

    errs_before = errors;
    reset_state();
    report_test("reset", errs_before);
    errs_before = errors;
    gpio_output();
    report_test("gpio output", errs_before);
    errs_before = errors;
    gpio_interrupts();
    report_test("gpio input and interrupts", errs_before);
    errs_before = errors;
    power_sequence();
    report_test("power off and on", errs_before);
    errs_before = errors;
    unmapped_access();
    report_test("unmapped and read-only", errs_before);
    errs_before = errors;
    back_to_back();
    report_test("back-to-back", errs_before);

    next_cycle();
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+.
mcu_pkg.sv
obi_demux.sv
gpio_ctrl.sv
power_ctrl.sv
mcu_top.sv
tb_mcu.sv
